// File: design/wb_arb_consts.svh
/*
 * Wishbone shared bus build constants
 * Master count, bus widths and SRAM size
 */
`ifndef WB_ARB_CONSTS_SVH
`define WB_ARB_CONSTS_SVH

// Masters sharing the bus
`define WB_ARB_MASTERS 4

`define WB_ADR_W 8   // Word address
`define WB_DAT_W 32

// SRAM words, address wraps at this depth
`define WB_SRAM_DEPTH 64

`endif

// File: design/arb_pkg.sv
/*
 * Arbitration types
 * Scheme codes, one-hot grant vector and master index
 */
`include "wb_arb_consts.svh"

package arb_pkg;

  // Codes 6 and 7 grant nothing
  typedef enum logic [2:0] {
    scheme_fix0 = 3'd0,
    scheme_fix1 = 3'd1,
    scheme_fix2 = 3'd2,
    scheme_fix3 = 3'd3,
    scheme_rr   = 3'd4,
    scheme_rand = 3'd5
  } arb_scheme_e;

  typedef logic [`WB_ARB_MASTERS-1:0] gnt_t;  // One-hot, zero when idle

  typedef logic [$clog2(`WB_ARB_MASTERS)-1:0] mst_idx_t;

endpackage

// File: design/bus_pkg.sv
/*
 * Wishbone bus types
 * Address, data and byte select
 */
`include "wb_arb_consts.svh"

package bus_pkg;

  typedef logic [`WB_ADR_W-1:0] adr_t;

  typedef logic [`WB_DAT_W-1:0] dat_t;

  // One bit per data byte
  typedef logic [`WB_DAT_W/8-1:0] sel_t;

endpackage

// File: design/pn_seq_gen.sv
/*
 * Pseudo-random favoured-master source
 * 3-bit Fibonacci LFSR, steps every cycle
 */
module pn_seq_gen (
  input  logic              clk,
  input  logic              rst_n,
  output arb_pkg::mst_idx_t rand_idx
);

  logic s1;
  logic s2;
  logic s3;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;  // Nonzero seed
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      s1 <= s1 ^ s3;
      s2 <= s1;
      s3 <= s2;
    end
  end

  assign rand_idx = {s3, s2};

endmodule

// File: design/grant_arbiter.sv
/*
 * Multi-scheme grant arbiter
 * Fixed priority, round robin or LFSR-favoured choice, registered,
 * held while the owning master keeps its cycle open
 */
`include "wb_arb_consts.svh"

module grant_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  arb_pkg::arb_scheme_e       scheme,
  input  logic [`WB_ARB_MASTERS-1:0] req,
  output arb_pkg::gnt_t              gnt
);

  arb_pkg::mst_idx_t rand_idx;
  arb_pkg::mst_idx_t last_idx;  // Last granted master
  arb_pkg::mst_idx_t next_idx;
  arb_pkg::gnt_t     rr_gnt;
  arb_pkg::gnt_t     pick_gnt;
  arb_pkg::gnt_t     gnt_d;
  logic              locked;

  // Favoured master first, then the rest in ascending order
  function automatic arb_pkg::gnt_t fav_pick(
    input logic [`WB_ARB_MASTERS-1:0] r,
    input arb_pkg::mst_idx_t          fav
  );
    arb_pkg::gnt_t g;
    g = '0;
    if (r[fav]) begin
      g[fav] = 1'b1;
    end else begin
      for (int i = `WB_ARB_MASTERS - 1; i >= 0; i--) begin
        if (r[i]) g = arb_pkg::gnt_t'(1) << i;  // Lowest wins
      end
    end
    return g;
  endfunction

  pn_seq_gen pn_seq_gen_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_idx (rand_idx)
  );

  // Search upward from last_idx + 1, wrapping
  always_comb begin : rr_search
    arb_pkg::mst_idx_t cand;
    rr_gnt = '0;
    for (int k = `WB_ARB_MASTERS; k >= 1; k--) begin
      cand = arb_pkg::mst_idx_t'(last_idx + k);
      if (req[cand]) rr_gnt = arb_pkg::gnt_t'(1) << cand;  // Nearest one kept
    end
  end

  always_comb begin
    case (scheme)
      arb_pkg::scheme_fix0: pick_gnt = fav_pick(req, arb_pkg::mst_idx_t'(0));
      arb_pkg::scheme_fix1: pick_gnt = fav_pick(req, arb_pkg::mst_idx_t'(1));
      arb_pkg::scheme_fix2: pick_gnt = fav_pick(req, arb_pkg::mst_idx_t'(2));
      arb_pkg::scheme_fix3: pick_gnt = fav_pick(req, arb_pkg::mst_idx_t'(3));
      arb_pkg::scheme_rr:   pick_gnt = rr_gnt;
      arb_pkg::scheme_rand: pick_gnt = fav_pick(req, rand_idx);
      default:              pick_gnt = '0;  // Invalid code
    endcase
  end

  // Bus lock, owner keeps the grant while its cyc is high
  assign locked = |(gnt & req);
  assign gnt_d  = locked ? gnt : pick_gnt;

  always_comb begin
    next_idx = last_idx;  // Idle keeps the pointer
    for (int i = 0; i < `WB_ARB_MASTERS; i++) begin
      if (gnt_d[i]) next_idx = arb_pkg::mst_idx_t'(i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt      <= '0;
      last_idx <= arb_pkg::mst_idx_t'(`WB_ARB_MASTERS - 1);
    end else begin
      gnt      <= gnt_d;
      last_idx <= next_idx;
    end
  end

endmodule

// File: design/wb_shared_bus.sv
/*
 * Wishbone shared bus interconnect
 * Routes the granted master to the slave, steers ack back to it
 * and broadcasts read data
 */
`include "wb_arb_consts.svh"

module wb_shared_bus (
  input  arb_pkg::gnt_t                          gnt,
  input  logic [`WB_ARB_MASTERS-1:0]             m_cyc,
  input  logic [`WB_ARB_MASTERS-1:0]             m_stb,
  input  logic [`WB_ARB_MASTERS-1:0]             m_we,
  input  bus_pkg::adr_t [`WB_ARB_MASTERS-1:0]    m_adr,
  input  bus_pkg::dat_t [`WB_ARB_MASTERS-1:0]    m_dat_w,
  input  bus_pkg::sel_t [`WB_ARB_MASTERS-1:0]    m_sel,
  output logic [`WB_ARB_MASTERS-1:0]             m_ack,
  output bus_pkg::dat_t                          m_dat_r,
  output logic                                   s_cyc,
  output logic                                   s_stb,
  output logic                                   s_we,
  output bus_pkg::adr_t                          s_adr,
  output bus_pkg::dat_t                          s_dat_w,
  output bus_pkg::sel_t                          s_sel,
  input  logic                                   s_ack,
  input  bus_pkg::dat_t                          s_dat_r
);

  arb_pkg::mst_idx_t own;  // Owner index
  logic              granted;

  // One-hot to index
  always_comb begin
    own = '0;
    for (int i = 0; i < `WB_ARB_MASTERS; i++) begin
      if (gnt[i]) own = arb_pkg::mst_idx_t'(i);
    end
  end

  assign granted = |gnt;

  // No grant keeps the slave idle
  assign s_cyc   = granted & m_cyc[own];
  assign s_stb   = granted & m_stb[own];
  assign s_we    = m_we[own];
  assign s_adr   = m_adr[own];
  assign s_dat_w = m_dat_w[own];
  assign s_sel   = m_sel[own];

  assign m_ack   = gnt & {`WB_ARB_MASTERS{s_ack}};  // Owner only
  assign m_dat_r = s_dat_r;

endmodule

// File: design/wb_sram_slave.sv
/*
 * Wishbone classic SRAM slave
 * Byte-select writes, registered reads, one-cycle ack
 */
`include "wb_arb_consts.svh"

module wb_sram_slave (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          s_cyc,
  input  logic          s_stb,
  input  logic          s_we,
  input  bus_pkg::adr_t s_adr,
  input  bus_pkg::dat_t s_dat_w,
  input  bus_pkg::sel_t s_sel,
  output logic          s_ack,
  output bus_pkg::dat_t s_dat_r
);

  localparam int AW = $clog2(`WB_SRAM_DEPTH);

  bus_pkg::dat_t   mem [`WB_SRAM_DEPTH];
  logic [AW-1:0]   word_a;
  logic            xfer;

  assign word_a = s_adr[AW-1:0];  // Wraps modulo depth

  // Fresh request, not the cycle already being acked
  assign xfer = s_cyc & s_stb & ~s_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_ack <= 1'b0;
    end else begin
      s_ack <= xfer;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      if (s_we) begin
        for (int b = 0; b < `WB_DAT_W / 8; b++) begin
          if (s_sel[b]) mem[word_a][8*b +: 8] <= s_dat_w[8*b +: 8];
        end
      end else begin
        s_dat_r <= mem[word_a];
      end
    end
  end

endmodule

// File: design/wb_arb_top.sv
/*
 * Four-master Wishbone shared bus
 * Grant arbiter, interconnect and one SRAM slave
 */
`include "wb_arb_consts.svh"

module wb_arb_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  arb_pkg::arb_scheme_e                scheme,
  input  logic [`WB_ARB_MASTERS-1:0]          m_cyc,
  input  logic [`WB_ARB_MASTERS-1:0]          m_stb,
  input  logic [`WB_ARB_MASTERS-1:0]          m_we,
  input  bus_pkg::adr_t [`WB_ARB_MASTERS-1:0] m_adr,
  input  bus_pkg::dat_t [`WB_ARB_MASTERS-1:0] m_dat_w,
  input  bus_pkg::sel_t [`WB_ARB_MASTERS-1:0] m_sel,
  output logic [`WB_ARB_MASTERS-1:0]          m_ack,
  output bus_pkg::dat_t                       m_dat_r,
  output arb_pkg::gnt_t                       gnt
);

  // Slave side
  logic          s_cyc;
  logic          s_stb;
  logic          s_we;
  bus_pkg::adr_t s_adr;
  bus_pkg::dat_t s_dat_w;
  bus_pkg::sel_t s_sel;
  logic          s_ack;
  bus_pkg::dat_t s_dat_r;

  grant_arbiter grant_arbiter_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .scheme (scheme),
    .req    (m_cyc),  // Requests are the cycle lines
    .gnt    (gnt)
  );

  wb_shared_bus wb_shared_bus_inst (
    .gnt     (gnt),
    .m_cyc   (m_cyc),
    .m_stb   (m_stb),
    .m_we    (m_we),
    .m_adr   (m_adr),
    .m_dat_w (m_dat_w),
    .m_sel   (m_sel),
    .m_ack   (m_ack),
    .m_dat_r (m_dat_r),
    .s_cyc   (s_cyc),
    .s_stb   (s_stb),
    .s_we    (s_we),
    .s_adr   (s_adr),
    .s_dat_w (s_dat_w),
    .s_sel   (s_sel),
    .s_ack   (s_ack),
    .s_dat_r (s_dat_r)
  );

  wb_sram_slave wb_sram_slave_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_cyc   (s_cyc),
    .s_stb   (s_stb),
    .s_we    (s_we),
    .s_adr   (s_adr),
    .s_dat_w (s_dat_w),
    .s_sel   (s_sel),
    .s_ack   (s_ack),
    .s_dat_r (s_dat_r)
  );

endmodule

// File: bench/wb_arb_assertions.sv
/*
 * Wishbone shared bus protocol assertions
 * Grant encoding, ack steering, bus lock and ack qualification
 */
`include "wb_arb_consts.svh"

module wb_arb_assertions (
  input logic                       clk,
  input logic                       rst_n,
  input arb_pkg::gnt_t              gnt,
  input logic [`WB_ARB_MASTERS-1:0] m_cyc,
  input logic [`WB_ARB_MASTERS-1:0] m_stb,
  input logic [`WB_ARB_MASTERS-1:0] m_ack
);

  timeunit 1ns;
  timeprecision 100ps;

  grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
    else $error("grant is neither one-hot nor zero");

  // Ack goes to the master that owned the bus when the slave took the request
  ack_to_owner: assert property (
    @(posedge clk) disable iff (!rst_n) (m_ack & ~$past(gnt)) == '0
  ) else $error("ack sent to a master that did not own the bus for that request");

  grant_held: assert property (
    @(posedge clk) disable iff (!rst_n) (|(gnt & m_cyc)) |=> $stable(gnt)
  ) else $error("grant moved while the owner kept its cycle open");

  ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n) (m_ack & ~m_stb) == '0)
    else $error("ack without a strobe");

endmodule

bind wb_arb_top wb_arb_assertions wb_arb_assertions_inst (
  .clk   (clk),
  .rst_n (rst_n),
  .gnt   (gnt),
  .m_cyc (m_cyc),
  .m_stb (m_stb),
  .m_ack (m_ack)
);

// File: bench/wb_arb_tb.sv
/*
 * Testbench for the four-master Wishbone shared bus
 * Drives the masters, models grants and SRAM contents, checks every cycle
 */
`include "wb_arb_consts.svh"

module wb_arb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 40;
  localparam int KIND_FILL   = 0;  // Full-word writes at consecutive addresses
  localparam int KIND_WSEL   = 1;
  localparam int KIND_READ   = 2;
  localparam int KIND_RAND   = 3;  // Random direction, address and sel
  // Fill and single master, fixed, round robin, random, invalid, contention
  localparam int XFER_TOTAL  = 96 + 32 + 24 + 16 + 4 + 72;
  localparam int WATCHDOG_NS = XFER_TOTAL * 12 * CLK_PERIOD;

  logic                                clk = 1'b0;
  logic                                rst_n;
  arb_pkg::arb_scheme_e                scheme;
  logic [`WB_ARB_MASTERS-1:0]          m_cyc;
  logic [`WB_ARB_MASTERS-1:0]          m_stb;
  logic [`WB_ARB_MASTERS-1:0]          m_we;
  bus_pkg::adr_t [`WB_ARB_MASTERS-1:0] m_adr;
  bus_pkg::dat_t [`WB_ARB_MASTERS-1:0] m_dat_w;
  bus_pkg::sel_t [`WB_ARB_MASTERS-1:0] m_sel;
  logic [`WB_ARB_MASTERS-1:0]          m_ack;
  bus_pkg::dat_t                       m_dat_r;
  arb_pkg::gnt_t                       gnt;

  logic [15:0] lfsr_q = 16'd57546;
  int          check_cnt = 0;
  int          mismatch_cnt = 0;
  int          issued [`WB_ARB_MASTERS];
  int          acks [`WB_ARB_MASTERS];

  // Reference state
  arb_pkg::gnt_t model_gnt;
  int            rr_last;
  logic [2:0]    pn_state;  // {s1, s2, s3}
  logic [7:0]    shadow [`WB_SRAM_DEPTH*4];

  wb_arb_top wb_arb_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .scheme  (scheme),
    .m_cyc   (m_cyc),
    .m_stb   (m_stb),
    .m_we    (m_we),
    .m_adr   (m_adr),
    .m_dat_w (m_dat_w),
    .m_sel   (m_sel),
    .m_ack   (m_ack),
    .m_dat_r (m_dat_r),
    .gnt     (gnt)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // 16-bit Fibonacci LFSR (x^16 + x^14 + x^13 + x^11 + 1) stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // Scheme choice among the open cycles without the bus lock
  function automatic arb_pkg::gnt_t expected_grant(input arb_pkg::arb_scheme_e sch,
                                                   input logic [3:0] cyc, input int last,
                                                   input logic [2:0] pn);
    int fav;
    int idx;
    case (sch)
      arb_pkg::scheme_fix0, arb_pkg::scheme_fix1,
      arb_pkg::scheme_fix2, arb_pkg::scheme_fix3: fav = int'(sch);
      arb_pkg::scheme_rand: fav = int'({pn[0], pn[1]});  // Output is {s3, s2}
      arb_pkg::scheme_rr: begin
        for (int k = 1; k <= `WB_ARB_MASTERS; k++) begin
          idx = (last + k) % `WB_ARB_MASTERS;
          if (cyc[idx]) return arb_pkg::gnt_t'(1) << idx;
        end
        return '0;
      end
      default: return '0;
    endcase
    if (cyc[fav]) return arb_pkg::gnt_t'(1) << fav;
    for (int i = 0; i < `WB_ARB_MASTERS; i++) begin
      if (cyc[i]) return arb_pkg::gnt_t'(1) << i;
    end
    return '0;
  endfunction

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                             input string what);
    check_cnt++;
    if (actual !== expected) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  always @(negedge clk) begin : compare
    arb_pkg::gnt_t next_gnt;
    int            w;
    logic [31:0]   exp_word;
    if (!rst_n) begin
      model_gnt = '0;
      rr_last   = `WB_ARB_MASTERS - 1;
      pn_state  = 3'b100;
      check_value(0, gnt, "grant in reset");
      check_value(0, m_ack, "ack in reset");
    end else begin
      check_value(model_gnt, gnt, "grant");
      check_value(0, m_ack & ~model_gnt, "ack outside grant");
      check_value(0, m_ack & ~m_stb, "ack without stb");
      for (int i = 0; i < `WB_ARB_MASTERS; i++) begin
        if (m_ack[i]) begin
          acks[i]++;
          w = m_adr[i] % `WB_SRAM_DEPTH;
          if (m_we[i]) begin
            for (int b = 0; b < `WB_DAT_W / 8; b++) begin
              if (m_sel[i][b]) shadow[w*4+b] = m_dat_w[i][8*b +: 8];
            end
          end else begin
            for (int b = 0; b < `WB_DAT_W / 8; b++) begin
              exp_word[8*b +: 8] = shadow[w*4+b];
            end
            check_value(exp_word, m_dat_r,
                        $sformatf("read data master %0d adr %h", i, m_adr[i]));
          end
        end
      end
      if (|(model_gnt & m_cyc)) begin
        next_gnt = model_gnt;  // Owner keeps the bus
      end else begin
        next_gnt = expected_grant(scheme, m_cyc, rr_last, pn_state);
      end
      for (int i = 0; i < `WB_ARB_MASTERS; i++) begin
        if (next_gnt[i]) rr_last = i;
      end
      model_gnt = next_gnt;
      pn_state  = {pn_state[2] ^ pn_state[0], pn_state[2], pn_state[1]};
    end
  end

  task automatic apply_reset();
    rst_n <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
  endtask

  task automatic drive_xfer(input int m, input int kind, input int base_adr);
    logic          we;
    bus_pkg::sel_t sel;
    bus_pkg::adr_t adr;
    adr = bus_pkg::adr_t'(base_adr);
    case (kind)
      KIND_FILL: begin
        we  = 1'b1;
        sel = '1;
      end
      KIND_WSEL: begin
        we  = 1'b1;
        sel = bus_pkg::sel_t'(rand_bits(4));
      end
      KIND_READ: begin
        we  = 1'b0;
        sel = '1;
      end
      default: begin
        we  = 1'(rand_bits(1));
        sel = bus_pkg::sel_t'(rand_bits(4));
        adr = bus_pkg::adr_t'(rand_bits(`WB_ADR_W));
      end
    endcase
    m_cyc[m]   <= 1'b1;
    m_stb[m]   <= 1'b1;
    m_we[m]    <= we;
    m_adr[m]   <= adr;
    m_sel[m]   <= sel;
    m_dat_w[m] <= bus_pkg::dat_t'(rand_bits(`WB_DAT_W));
    issued[m]++;
  endtask

  // Chained transfers under one cycle with the next request driven on the ack edge
  task automatic run_burst(input int m, input int n, input int gap_bits, input int kind,
                           input int base);
    int gap;
    gap = int'(rand_bits(gap_bits));
    repeat (gap + 1) @(posedge clk);
    for (int k = 0; k < n; k++) begin
      drive_xfer(m, kind, base + k);
      do begin
        @(posedge clk);
      end while (!m_ack[m]);
    end
    m_cyc[m] <= 1'b0;
    m_stb[m] <= 1'b0;
  endtask

  task automatic run_all(input int n, input int gap_bits, input int kind);
    fork
      run_burst(0, n, gap_bits, kind, 0);
      run_burst(1, n, gap_bits, kind, 0);
      run_burst(2, n, gap_bits, kind, 0);
      run_burst(3, n, gap_bits, kind, 0);
    join
  endtask

  initial begin : main
    rst_n   <= 1'b0;
    scheme  <= arb_pkg::scheme_fix0;
    m_cyc   <= '0;
    m_stb   <= '0;
    m_we    <= '0;
    m_adr   <= '0;
    m_dat_w <= '0;
    m_sel   <= '0;
    apply_reset();

    run_burst(0, `WB_SRAM_DEPTH, 0, KIND_FILL, 0);
    run_burst(0, 16, 0, KIND_WSEL, 8);
    run_burst(0, 16, 0, KIND_READ, 8);

    for (int s = 0; s < 4; s++) begin
      scheme <= arb_pkg::arb_scheme_e'(s);
      run_all(2, 0, KIND_RAND);  // All four open their cycles together
    end

    apply_reset();  // Round robin starts after index 3
    scheme <= arb_pkg::scheme_rr;
    repeat (4) run_all(1, 0, KIND_RAND);
    repeat (4) begin
      fork
        run_burst(0, 1, 0, KIND_RAND, 0);
        run_burst(2, 1, 0, KIND_RAND, 0);
      join
    end

    scheme <= arb_pkg::scheme_rand;
    repeat (4) run_all(1, 1, KIND_RAND);

    fork
      run_all(1, 0, KIND_RAND);
      begin
        scheme <= arb_pkg::arb_scheme_e'(3'd6);
        repeat (8) @(posedge clk);
        scheme <= arb_pkg::arb_scheme_e'(3'd7);
        repeat (8) @(posedge clk);
        scheme <= arb_pkg::scheme_rr;
      end
    join

    for (int s = 0; s < 6; s++) begin
      scheme <= arb_pkg::arb_scheme_e'(s);
      run_all(3, 2, KIND_RAND);
    end

    repeat (4) @(posedge clk);
    for (int i = 0; i < `WB_ARB_MASTERS; i++) begin
      check_value(issued[i], acks[i], $sformatf("ack count master %0d", i));
    end
    $display("Checks: %0d, mismatches: %0d", check_cnt, mismatch_cnt);
    if (mismatch_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the bus transfers did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks: %0d, mismatches: %0d", check_cnt, mismatch_cnt);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+design
design/arb_pkg.sv
design/bus_pkg.sv
design/pn_seq_gen.sv
design/grant_arbiter.sv
design/wb_shared_bus.sv
design/wb_sram_slave.sv
design/wb_arb_top.sv
bench/wb_arb_assertions.sv
bench/wb_arb_tb.sv

// File: Bender.yml
package:
  name: wb_arb

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/arb_pkg.sv
      - design/bus_pkg.sv
      - design/pn_seq_gen.sv
      - design/grant_arbiter.sv
      - design/wb_shared_bus.sv
      - design/wb_sram_slave.sv
      - design/wb_arb_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/wb_arb_assertions.sv
      - bench/wb_arb_tb.sv
